// File: bus_types_pkg.sv
package bus_types_pkg;

    // Width of one word carried by a frame
    localparam int unsigned WORD_BITS = 8;

    // Number of bit slots in one frame, used for the slot counter width
    localparam int unsigned SLOT_COUNT = 8;

    // One byte carried in one frame on a serial line
    typedef logic [WORD_BITS-1:0] frame_word_t;

    // Position of a bit slot within a frame, 0 is the first slot
    typedef logic [$clog2(SLOT_COUNT)-1:0] bit_index_t;

endpackage

// File: slot_pkg.sv
package slot_pkg;

    // Converter ports on the 40-pin board
    localparam int unsigned NUM_PORTS = 4;

    // One hardware-configuration byte per port
    localparam int unsigned HWCON_BITS = 8;

    // Number of a converter port, 0 to 3
    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

    // One bit per port, bit i for port i
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // All four configuration bytes, port i in bits 8i to 8i+7
    typedef logic [NUM_PORTS*HWCON_BITS-1:0] hwcon_bank_t;

    // ADC overflow flags, MSB first R3 L3 R2 L2 R1 L1 R0 L0
    typedef logic [2*NUM_PORTS-1:0] ovf_flags_t;

endpackage

// File: bus_clock_gen.sv
module bus_clock_gen import bus_types_pkg::*; #(
    parameter int unsigned CLK_DIV = 16
) (
    input  logic clk,
    input  logic reset,
    output logic spi_mclk,
    output logic srclk,
    output logic bit_tick,
    output logic frame_start,
    output logic sample_tick,
    output logic frame_end
);

    localparam int unsigned DIV_W = $clog2(CLK_DIV);
    localparam int unsigned HALF = CLK_DIV / 2;

    // Last counts of the low and the high half of a bus clock period
    localparam logic [DIV_W-1:0] RISE_AT = DIV_W'(HALF - 1);
    localparam logic [DIV_W-1:0] FALL_AT = DIV_W'(CLK_DIV - 1);
    localparam bit_index_t LAST_SLOT = '1;

    logic [DIV_W-1:0] div_count;
    bit_index_t       slot_count;
    logic             srclk_q;

    // Free-running divider, wraps by itself since CLK_DIV is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // Low for the first half of the period, high for the second
    assign spi_mclk = div_count[DIV_W-1];

    assign bit_tick    = (div_count == RISE_AT);
    assign sample_tick = (div_count == FALL_AT);

    // Starts at the last slot so the first bit slot opens a frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_count <= LAST_SLOT;
        end else if (bit_tick) begin
            slot_count <= slot_count + 1'b1;
        end
    end

    assign frame_start = bit_tick && (slot_count == LAST_SLOT);
    assign frame_end   = sample_tick && (slot_count == LAST_SLOT);

    // Strobe covers slot 0 exactly, updated with the rising bus clock
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            srclk_q <= 1'b0;
        end else if (bit_tick) begin
            srclk_q <= frame_start;
        end
    end

    assign srclk = srclk_q;

endmodule

// File: frame_serializer.sv
module frame_serializer import bus_types_pkg::*; #(
    parameter int unsigned FRAME_BITS = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_start,
    input  logic        bit_tick,
    input  frame_word_t word,
    output logic        serial
);

    logic [FRAME_BITS-1:0] shift_q;

    // Load at the frame boundary, then move one bit up per slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shift_q <= '0;
        end else if (frame_start) begin
            shift_q <= word;
        end else if (bit_tick) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    // MSB goes out first
    assign serial = shift_q[FRAME_BITS-1];

endmodule

// File: frame_deserializer.sv
module frame_deserializer import bus_types_pkg::*; #(
    parameter int unsigned FRAME_BITS = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_tick,
    input  logic        frame_end,
    input  logic        serial,
    output frame_word_t word,
    output logic        status_valid
);

    logic [FRAME_BITS-1:0] shift_q;
    logic [FRAME_BITS-1:0] shift_next;

    // First sampled bit ends up as the MSB after a full frame
    assign shift_next = {shift_q[FRAME_BITS-2:0], serial};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shift_q <= '0;
        end else if (sample_tick) begin
            shift_q <= shift_next;
        end
    end

    // The last bit arrives with frame_end, so take it straight from shift_next
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (frame_end) begin
            word <= frame_word_t'(shift_next);
        end
    end

    // One-cycle pulse alongside the new word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status_valid <= 1'b0;
        end else begin
            status_valid <= frame_end;
        end
    end

endmodule

// File: control_frame_builder.sv
module control_frame_builder import bus_types_pkg::*, slot_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_start,
    input  port_id_t    spi_port_id,
    input  logic        spi_direction,
    input  port_mask_t  clksel,
    input  hwcon_bank_t hwcons,
    output frame_word_t adc_cs_word,
    output frame_word_t dac_cs_word,
    output frame_word_t clksel_word,
    output frame_word_t hwcon_word
);

    port_mask_t adc_mask;
    port_mask_t dac_mask;
    port_id_t   hwcon_index;

    // Select exactly one converter: direction 1 is an ADC, 0 is a DAC
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            adc_mask[i] = (spi_port_id == port_id_t'(i)) && spi_direction;
            dac_mask[i] = (spi_port_id == port_id_t'(i)) && !spi_direction;
        end
    end

    // Masks sit in the low nibble, upper nibble stays clear
    assign adc_cs_word = {{($bits(frame_word_t) - NUM_PORTS){1'b0}}, adc_mask};
    assign dac_cs_word = {{($bits(frame_word_t) - NUM_PORTS){1'b0}}, dac_mask};
    assign clksel_word = {{($bits(frame_word_t) - NUM_PORTS){1'b0}}, clksel};

    // Port whose configuration byte goes out in the next frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hwcon_index <= '0;
        end else if (frame_start) begin
            hwcon_index <= hwcon_index + 1'b1;
        end
    end

    // Serializer loads this on the same frame_start that moves the index on
    assign hwcon_word = hwcons[HWCON_BITS*hwcon_index +: HWCON_BITS];

endmodule

// File: converter_bus_top.sv
module converter_bus_top import bus_types_pkg::*, slot_pkg::*; #(
    parameter int unsigned CLK_DIV    = 16,
    parameter int unsigned FRAME_BITS = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  port_id_t    spi_port_id,
    input  logic        spi_direction,
    input  port_mask_t  clksel,
    input  hwcon_bank_t hwcons,
    input  logic        custom_adc_ovf,
    input  logic        custom_dirchan,
    output logic        spi_mclk,
    output logic        custom_srclk,
    output logic        spi_adc_cs,
    output logic        spi_dac_cs,
    output logic        custom_clksel,
    output logic        custom_hwcon,
    output ovf_flags_t  aovf,
    output port_mask_t  direction,
    output port_mask_t  num_channels,
    output logic        status_valid
);

    logic bit_tick;
    logic frame_start;
    logic sample_tick;
    logic frame_end;

    frame_word_t adc_cs_word;
    frame_word_t dac_cs_word;
    frame_word_t clksel_word;
    frame_word_t hwcon_word;
    frame_word_t dirchan_word;

    bus_clock_gen #(
        .CLK_DIV(CLK_DIV)
    ) bus_clock_gen_i (
        .clk(clk),
        .reset(reset),
        .spi_mclk(spi_mclk),
        .srclk(custom_srclk),
        .bit_tick(bit_tick),
        .frame_start(frame_start),
        .sample_tick(sample_tick),
        .frame_end(frame_end)
    );

    control_frame_builder control_frame_builder_i (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .spi_port_id(spi_port_id),
        .spi_direction(spi_direction),
        .clksel(clksel),
        .hwcons(hwcons),
        .adc_cs_word(adc_cs_word),
        .dac_cs_word(dac_cs_word),
        .clksel_word(clksel_word),
        .hwcon_word(hwcon_word)
    );

    // Outgoing control words, one serial line each
    frame_serializer #(.FRAME_BITS(FRAME_BITS)) ser_adc_cs (
        .clk(clk), .reset(reset), .frame_start(frame_start), .bit_tick(bit_tick),
        .word(adc_cs_word), .serial(spi_adc_cs)
    );

    frame_serializer #(.FRAME_BITS(FRAME_BITS)) ser_dac_cs (
        .clk(clk), .reset(reset), .frame_start(frame_start), .bit_tick(bit_tick),
        .word(dac_cs_word), .serial(spi_dac_cs)
    );

    frame_serializer #(.FRAME_BITS(FRAME_BITS)) ser_clksel (
        .clk(clk), .reset(reset), .frame_start(frame_start), .bit_tick(bit_tick),
        .word(clksel_word), .serial(custom_clksel)
    );

    frame_serializer #(.FRAME_BITS(FRAME_BITS)) ser_hwcon (
        .clk(clk), .reset(reset), .frame_start(frame_start), .bit_tick(bit_tick),
        .word(hwcon_word), .serial(custom_hwcon)
    );

    // Incoming status words, both finish on the same cycle
    frame_deserializer #(.FRAME_BITS(FRAME_BITS)) deser_ovf (
        .clk(clk), .reset(reset), .sample_tick(sample_tick), .frame_end(frame_end),
        .serial(custom_adc_ovf), .word(aovf), .status_valid(status_valid)
    );

    frame_deserializer #(.FRAME_BITS(FRAME_BITS)) deser_dirchan (
        .clk(clk), .reset(reset), .sample_tick(sample_tick), .frame_end(frame_end),
        .serial(custom_dirchan), .word(dirchan_word), .status_valid()
    );

    // Low nibble is direction (1 = ADC), high nibble is channel count (1 = 8-ch)
    assign direction    = dirchan_word[NUM_PORTS-1:0];
    assign num_channels = dirchan_word[2*NUM_PORTS-1:NUM_PORTS];

endmodule

// File: tb_converter_bus.sv
module tb_converter_bus import bus_types_pkg::*, slot_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_DIV    = 16;
    localparam int unsigned FRAME_BITS = 8;
    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned NUM_FRAMES = 50;
    localparam int unsigned FRAME_NS   = CLK_PERIOD * CLK_DIV * FRAME_BITS;
    // Enough frames for the run plus a margin for reset and draining
    localparam int unsigned WATCHDOG_NS = (NUM_FRAMES + 9) * FRAME_NS;
    localparam logic [31:0] SEED = 32'h13b0c156;

    logic        clk;
    logic        reset;
    port_id_t    spi_port_id;
    logic        spi_direction;
    port_mask_t  clksel;
    hwcon_bank_t hwcons;
    logic        custom_adc_ovf;
    logic        custom_dirchan;
    logic        spi_mclk;
    logic        custom_srclk;
    logic        spi_adc_cs;
    logic        spi_dac_cs;
    logic        custom_clksel;
    logic        custom_hwcon;
    ovf_flags_t  aovf;
    port_mask_t  direction;
    port_mask_t  num_channels;
    logic        status_valid;

    logic [31:0] rng_state;
    logic        prev_mclk, prev_srclk;
    logic        mclk_rise, mclk_fall, srclk_rise, srclk_fall;
    logic        period_ready, srclk_len_ready, frame_slots_ready, frame_done;
    int          cyc_count, high_count, rises, meas_period, meas_high;
    int          srclk_cnt, meas_srclk_len, slot_rises, meas_frame_slots;
    int          tb_slot, frame_idx, frames_started, frames_done;
    int          frame_checks, status_checks;
    frame_word_t cap_adc, cap_dac, cap_clksel, cap_hwcon;
    frame_word_t exp_adc, exp_dac, exp_clksel, exp_hwcon;
    frame_word_t board_ovf, board_dirchan;
    logic        st_valid;
    ovf_flags_t  st_aovf;
    port_mask_t  st_direction, st_num_channels;

    converter_bus_top #(
        .CLK_DIV(CLK_DIV),
        .FRAME_BITS(FRAME_BITS)
    ) converter_bus_top_i (
        .clk(clk),
        .reset(reset),
        .spi_port_id(spi_port_id),
        .spi_direction(spi_direction),
        .clksel(clksel),
        .hwcons(hwcons),
        .custom_adc_ovf(custom_adc_ovf),
        .custom_dirchan(custom_dirchan),
        .spi_mclk(spi_mclk),
        .custom_srclk(custom_srclk),
        .spi_adc_cs(spi_adc_cs),
        .spi_dac_cs(spi_dac_cs),
        .custom_clksel(custom_clksel),
        .custom_hwcon(custom_hwcon),
        .aovf(aovf),
        .direction(direction),
        .num_channels(num_channels),
        .status_valid(status_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error %s expected %0h actual %0h", name, expected, actual);
        $display("Errors found");
        $fatal(1, "check %s failed", name);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic drive_random_controls();
        rng_state = xorshift32(rng_state);
        spi_port_id = rng_state[1:0];
        spi_direction = rng_state[9];
        clksel = rng_state[19:16];
        rng_state = xorshift32(rng_state);
        hwcons = rng_state;
    endtask

    // Latch what the DUT sampled at frame_start and pick new board status bytes
    task automatic start_frame();
        frame_idx = frames_started;
        frames_started++;
        exp_adc = '0;
        exp_dac = '0;
        if (spi_direction) begin
            exp_adc[spi_port_id] = 1'b1;
        end else begin
            exp_dac[spi_port_id] = 1'b1;
        end
        exp_clksel = {4'h0, clksel};
        exp_hwcon = hwcons[HWCON_BITS*(frame_idx % NUM_PORTS) +: HWCON_BITS];
        rng_state = xorshift32(rng_state);
        board_ovf = rng_state[7:0];
        board_dirchan = rng_state[15:8];
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Edge detection, board model, frame capture and status sampling
    always @(negedge clk) begin
        if (reset) begin
            prev_mclk = 1'b0;
            prev_srclk = 1'b0;
            period_ready = 1'b0;
            srclk_len_ready = 1'b0;
            frame_slots_ready = 1'b0;
            frame_done = 1'b0;
            srclk_rise = 1'b0;
            mclk_rise = 1'b0;
            cyc_count = 0;
            high_count = 0;
            rises = 0;
            srclk_cnt = 0;
            slot_rises = 0;
            tb_slot = 0;
            st_valid = 1'b0;
        end else begin
            mclk_rise = spi_mclk && !prev_mclk;
            mclk_fall = !spi_mclk && prev_mclk;
            srclk_rise = custom_srclk && !prev_srclk;
            srclk_fall = !custom_srclk && prev_srclk;
            period_ready = 1'b0;
            srclk_len_ready = 1'b0;
            frame_slots_ready = 1'b0;
            frame_done = 1'b0;

            if (mclk_rise) begin
                meas_period = cyc_count;
                meas_high = high_count;
                period_ready = (rises > 0);
                rises++;
                cyc_count = 1;
                high_count = 1;
            end else begin
                cyc_count++;
                if (spi_mclk) high_count++;
            end

            if (custom_srclk) srclk_cnt++;
            if (srclk_fall) begin
                meas_srclk_len = srclk_cnt;
                srclk_len_ready = 1'b1;
                srclk_cnt = 0;
            end

            // Board puts a new bit on each line as the bus clock rises
            if (mclk_rise) begin
                if (custom_srclk) begin
                    meas_frame_slots = slot_rises;
                    frame_slots_ready = (frames_started > 0);
                    slot_rises = 1;
                    tb_slot = 0;
                    start_frame();
                end else begin
                    slot_rises++;
                    tb_slot++;
                end
                custom_adc_ovf = board_ovf[FRAME_BITS-1-tb_slot];
                custom_dirchan = board_dirchan[FRAME_BITS-1-tb_slot];
                if (tb_slot == FRAME_BITS - 1) drive_random_controls();
            end

            if (mclk_fall) begin
                cap_adc = {cap_adc[FRAME_BITS-2:0], spi_adc_cs};
                cap_dac = {cap_dac[FRAME_BITS-2:0], spi_dac_cs};
                cap_clksel = {cap_clksel[FRAME_BITS-2:0], custom_clksel};
                cap_hwcon = {cap_hwcon[FRAME_BITS-2:0], custom_hwcon};
                if (tb_slot == FRAME_BITS - 1 && frames_started > 0) begin
                    frame_done = 1'b1;
                    frames_done++;
                end
            end

            st_valid = status_valid;
            st_aovf = aovf;
            st_direction = direction;
            st_num_channels = num_channels;
            prev_mclk = spi_mclk;
            prev_srclk = custom_srclk;
        end
    end

    reset_low: assert property (@(posedge clk) reset |-> (!spi_mclk && !custom_srclk
            && !spi_adc_cs && !spi_dac_cs && !custom_clksel && !custom_hwcon
            && !status_valid && aovf == '0 && direction == '0 && num_channels == '0))
        else report_problem("outputs were not low while reset was asserted");

    mclk_period: assert property (@(posedge clk) period_ready |-> meas_period == CLK_DIV)
        else report_mismatch("mclk_period", CLK_DIV, meas_period);
    mclk_high: assert property (@(posedge clk) period_ready |-> meas_high == CLK_DIV / 2)
        else report_mismatch("mclk_high", CLK_DIV / 2, meas_high);
    srclk_len: assert property (@(posedge clk) srclk_len_ready |-> meas_srclk_len == CLK_DIV)
        else report_mismatch("srclk_length", CLK_DIV, meas_srclk_len);
    srclk_every: assert property (@(posedge clk)
            frame_slots_ready |-> meas_frame_slots == FRAME_BITS)
        else report_mismatch("srclk_spacing", FRAME_BITS, meas_frame_slots);
    srclk_align: assert property (@(posedge clk) srclk_rise |-> mclk_rise)
        else report_problem("custom_srclk rose without a rising spi_mclk");

    adc_frame: assert property (@(posedge clk) frame_done |-> cap_adc == exp_adc)
        else report_mismatch("adc_cs", exp_adc, cap_adc);
    dac_frame: assert property (@(posedge clk) frame_done |-> cap_dac == exp_dac)
        else report_mismatch("dac_cs", exp_dac, cap_dac);
    cs_exclusive: assert property (@(posedge clk) frame_done |->
            ((cap_adc == '0 || cap_dac == '0) && cap_adc[7:4] == '0 && cap_dac[7:4] == '0))
        else report_problem("both chip-select frames active or an upper nibble set");
    clksel_frame: assert property (@(posedge clk) frame_done |-> cap_clksel == exp_clksel)
        else report_mismatch("clksel", exp_clksel, cap_clksel);
    hwcon_frame: assert property (@(posedge clk) frame_done |-> cap_hwcon == exp_hwcon)
        begin
            if (frame_done) frame_checks++;
        end
        else report_mismatch("hwcon", exp_hwcon, cap_hwcon);

    status_ovf: assert property (@(posedge clk) st_valid |-> st_aovf == board_ovf)
        begin
            if (st_valid) status_checks++;
        end
        else report_mismatch("aovf", board_ovf, st_aovf);
    status_dir: assert property (@(posedge clk)
            st_valid |-> st_direction == board_dirchan[3:0])
        else report_mismatch("direction", board_dirchan[3:0], st_direction);
    status_nch: assert property (@(posedge clk)
            st_valid |-> st_num_channels == board_dirchan[7:4])
        else report_mismatch("num_channels", board_dirchan[7:4], st_num_channels);

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all frames were checked");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial begin
        rng_state = SEED;
        frames_started = 0;
        frames_done = 0;
        frame_checks = 0;
        status_checks = 0;
        custom_adc_ovf = 1'b0;
        custom_dirchan = 1'b0;
        board_ovf = '0;
        board_dirchan = '0;
        cap_adc = '0;
        cap_dac = '0;
        cap_clksel = '0;
        cap_hwcon = '0;
        reset = 1'b1;
        drive_random_controls();
        repeat (2) @(negedge clk);
        reset = 1'b0;

        wait (frames_done >= NUM_FRAMES);
        repeat (4) @(negedge clk);
        if (frame_checks >= NUM_FRAMES && status_checks >= NUM_FRAMES) begin
            $display("No errors");
            $finish;
        end else begin
            $display("too few frame or status checks were reached");
            $display("Errors found");
            $fatal(1, "incomplete run");
        end
    end

endmodule

// File: src.f
bus_types_pkg.sv
slot_pkg.sv
bus_clock_gen.sv
frame_serializer.sv
frame_deserializer.sv
control_frame_builder.sv
converter_bus_top.sv
tb_converter_bus.sv
